//--- logic/trig_pkg.sv
package trig_pkg;

	localparam int num_routes = 4;
	localparam int num_cmp    = 4;
	localparam int atom_w     = 32;
	localparam int dut_w      = 29;

	typedef logic [num_routes-1:0] route_t;

	// Low address bits select a byte within a four-byte block.
	typedef logic [1:0] byte_sel_t;

	// Snapshot of the device bus, all bits active high.
	typedef struct packed {
		logic        reset;
		logic        phi;
		logic        wr;
		logic        rd;
		logic        cs_xram;
		logic [7:0]  data;
		logic        cs_rom;
		logic [14:0] adr;
	} dut_word_t;

	// Host address map.
	localparam logic [15:0] adr_atom_base = 16'hff10;
	localparam logic [15:0] adr_ones_set  = 16'hff14;
	localparam logic [15:0] adr_pa_base   = 16'hff40;
	localparam logic [15:0] adr_dut_base  = 16'hff50;

endpackage

//--- logic/reg_bus_if.sv
interface reg_bus_if;

	trig_pkg::byte_sel_t           byte_sel;
	logic [7:0]                    wdata;
	logic [trig_pkg::atom_w-1:0]   atom;

	// One-cycle strobes, first cycle of a host write only.
	logic                          ones_wr;
	logic                          trig_wr;
	logic                          cmp_wr;
	logic                          pa_wr;

	modport decode (
		output byte_sel,
		output wdata,
		output atom,
		output ones_wr,
		output trig_wr,
		output cmp_wr,
		output pa_wr
	);

	modport match (
		input  wdata,
		input  atom,
		input  ones_wr,
		input  trig_wr,
		input  cmp_wr
	);

	modport porta (
		input  byte_sel,
		input  wdata,
		input  atom,
		input  pa_wr
	);

endinterface

//--- logic/host_decode.sv
module host_decode (
	input  logic                cpuclk,
	input  logic                f_reset,
	input  logic [15:0]         cpu_adr,
	input  logic [7:0]          cpu_wdata,
	input  logic                cpu_wr,
	output logic [7:0]          cpu_rdata,
	input  logic [7:0]          pa_out,
	input  trig_pkg::dut_word_t dut_snap,
	reg_bus_if.decode           rb
);

	logic                        r_cpu_wr;
	logic                        wr_first;
	logic                        cs_atom;
	logic                        cs_ones_set;
	logic                        cs_pa;
	logic                        cs_dut;
	trig_pkg::byte_sel_t         byte_sel;
	logic [trig_pkg::atom_w-1:0] atom;

	assign byte_sel = cpu_adr[1:0];

	// Block selects ignore the byte select bits.
	assign cs_atom     = cpu_adr[15:2] == trig_pkg::adr_atom_base[15:2];
	assign cs_ones_set = cpu_adr == trig_pkg::adr_ones_set;
	assign cs_pa       = cpu_adr[15:2] == trig_pkg::adr_pa_base[15:2];
	assign cs_dut      = cpu_adr[15:2] == trig_pkg::adr_dut_base[15:2];

	always_ff @(posedge cpuclk) begin
		if (f_reset)
			r_cpu_wr <= 1'b0;
		else
			r_cpu_wr <= cpu_wr;
	end

	// A held write counts once.
	assign wr_first = cpu_wr && !r_cpu_wr;

	// Atomic register, loaded little-endian.
	always_ff @(posedge cpuclk) begin
		if (wr_first && cs_atom) begin
			case (byte_sel)
			2'd0: atom[7:0]   <= cpu_wdata;
			2'd1: atom[15:8]  <= cpu_wdata;
			2'd2: atom[23:16] <= cpu_wdata;
			2'd3: atom[31:24] <= cpu_wdata;
			endcase
		end
	end

	assign rb.byte_sel = byte_sel;
	assign rb.wdata    = cpu_wdata;
	assign rb.atom     = atom;
	assign rb.ones_wr  = wr_first && cs_ones_set;
	assign rb.trig_wr  = wr_first && cs_dut && byte_sel == 2'd1;
	assign rb.cmp_wr   = wr_first && cs_dut && byte_sel == 2'd3;
	assign rb.pa_wr    = wr_first && cs_pa;

	always_comb begin
		cpu_rdata = 8'hff;

		if (cs_atom) begin
			case (byte_sel)
			2'd0: cpu_rdata = atom[7:0];
			2'd1: cpu_rdata = atom[15:8];
			2'd2: cpu_rdata = atom[23:16];
			2'd3: cpu_rdata = atom[31:24];
			endcase
		end else if (cs_pa && byte_sel == 2'd0) begin
			cpu_rdata = pa_out;
		end else if (cs_dut) begin
			case (byte_sel)
			2'd0: cpu_rdata = dut_snap[7:0];
			2'd1: cpu_rdata = dut_snap[15:8];
			2'd2: cpu_rdata = dut_snap[23:16];
			// Top five snapshot bits, zero above.
			2'd3: cpu_rdata = {3'b000, dut_snap[trig_pkg::dut_w-1:24]};
			endcase
		end
	end

endmodule

//--- logic/bus_match.sv
module bus_match (
	input  logic                 cpuclk,
	input  logic                 f_reset,
	input  logic [14:0]          dut_adr,
	input  logic [7:0]           dut_data,
	input  logic                 dut_rd,
	input  logic                 dut_wr,
	input  logic                 dut_cs_rom,
	input  logic                 dut_cs_xram,
	input  logic                 dut_phi,
	input  logic                 dut_reset,
	reg_bus_if.match             rb,
	output trig_pkg::dut_word_t  dut_snap,
	output trig_pkg::route_t     route
);

	trig_pkg::route_t           ones_set;
	trig_pkg::route_t           cmp_route [trig_pkg::num_cmp];
	logic [trig_pkg::dut_w-1:0] cmp_value [trig_pkg::num_cmp];
	logic [trig_pkg::dut_w-1:0] cmp_mask  [trig_pkg::num_cmp];
	trig_pkg::route_t           next_route;

	// Device bus sampled every cycle.
	always_ff @(posedge cpuclk) begin
		dut_snap.reset   <= dut_reset;
		dut_snap.phi     <= dut_phi;
		dut_snap.wr      <= dut_wr;
		dut_snap.rd      <= dut_rd;
		dut_snap.cs_xram <= dut_cs_xram;
		dut_snap.data    <= dut_data;
		dut_snap.cs_rom  <= dut_cs_rom;
		dut_snap.adr     <= dut_adr;
	end

	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			ones_set <= '0;
			for (int i = 0; i < trig_pkg::num_cmp; i++) begin
				cmp_route[i] <= '0;
				cmp_value[i] <= '0;
				cmp_mask[i]  <= '0;
			end
		end else begin
			if (rb.ones_wr)
				ones_set <= rb.atom[trig_pkg::num_routes-1:0];
			for (int i = 0; i < trig_pkg::num_cmp; i++) begin
				if (rb.trig_wr && rb.wdata[i])
					cmp_route[i] <= rb.atom[trig_pkg::num_routes-1:0];
				if (rb.cmp_wr && rb.wdata[i])
					cmp_value[i] <= rb.atom[trig_pkg::dut_w-1:0];
				// Upper nibble of the write selects masks.
				if (rb.cmp_wr && rb.wdata[i+4])
					cmp_mask[i] <= rb.atom[trig_pkg::dut_w-1:0];
			end
		end
	end

	always_comb begin
		next_route = ones_set;
		for (int i = 0; i < trig_pkg::num_cmp; i++) begin
			if ((dut_snap & cmp_mask[i]) == (cmp_value[i] & cmp_mask[i]))
				next_route = next_route | cmp_route[i];
		end
	end

	always_ff @(posedge cpuclk) begin
		if (f_reset)
			route <= '0;
		else
			route <= next_route;
	end

endmodule

//--- logic/port_a_ctrl.sv
module port_a_ctrl (
	input  logic             cpuclk,
	input  logic             f_reset,
	reg_bus_if.porta         rb,
	input  trig_pkg::route_t route,
	output logic [7:0]       pa_out
);

	logic [7:0]       set_mask;
	logic [7:0]       reset_mask;
	logic [7:0]       set_eff;
	logic [7:0]       reset_eff;
	trig_pkg::route_t trig_set;
	trig_pkg::route_t trig_reset;

	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			set_mask   <= '0;
			reset_mask <= '0;
			trig_set   <= '0;
			trig_reset <= '0;
		end else if (rb.pa_wr) begin
			case (rb.byte_sel)
			2'd0: set_mask <= rb.wdata;
			2'd1: reset_mask <= rb.wdata;
			2'd2:
				if (rb.wdata == 8'd1)
					trig_set <= rb.atom[trig_pkg::num_routes-1:0];
			2'd3:
				if (rb.wdata == 8'd1)
					trig_reset <= rb.atom[trig_pkg::num_routes-1:0];
			endcase
		end
	end

	// Route triggers act on bit 0 only.
	always_comb begin
		set_eff      = set_mask;
		reset_eff    = reset_mask;
		set_eff[0]   = set_mask[0] | |(trig_set & route);
		reset_eff[0] = reset_mask[0] | |(trig_reset & route);
	end

	// Reset wins over set.
	always_ff @(posedge cpuclk) begin
		if (f_reset)
			pa_out <= '0;
		else
			pa_out <= (pa_out | set_eff) & ~reset_eff;
	end

endmodule

//--- logic/trig_top.sv
module trig_top (
	input  logic             cpuclk,
	input  logic             f_reset,

	input  logic [15:0]      cpu_adr,
	input  logic [7:0]       cpu_wdata,
	input  logic             cpu_wr,
	output logic [7:0]       cpu_rdata,

	input  logic [14:0]      dut_adr,
	input  logic [7:0]       dut_data,
	input  logic             dut_rd,
	input  logic             dut_wr,
	input  logic             dut_cs_rom,
	input  logic             dut_cs_xram,
	input  logic             dut_phi,
	input  logic             dut_reset,

	output logic [7:0]       pa_out,
	output trig_pkg::route_t route
);

	trig_pkg::dut_word_t dut_snap;

	reg_bus_if rb ();

	host_decode u_host_decode (
		.cpuclk    (cpuclk),
		.f_reset   (f_reset),
		.cpu_adr   (cpu_adr),
		.cpu_wdata (cpu_wdata),
		.cpu_wr    (cpu_wr),
		.cpu_rdata (cpu_rdata),
		.pa_out    (pa_out),
		.dut_snap  (dut_snap),
		.rb        (rb.decode)
	);

	// Device pins arrive as active-high levels.
	bus_match u_bus_match (
		.cpuclk      (cpuclk),
		.f_reset     (f_reset),
		.dut_adr     (dut_adr),
		.dut_data    (dut_data),
		.dut_rd      (dut_rd),
		.dut_wr      (dut_wr),
		.dut_cs_rom  (dut_cs_rom),
		.dut_cs_xram (dut_cs_xram),
		.dut_phi     (dut_phi),
		.dut_reset   (dut_reset),
		.rb          (rb.match),
		.dut_snap    (dut_snap),
		.route       (route)
	);

	port_a_ctrl u_port_a_ctrl (
		.cpuclk  (cpuclk),
		.f_reset (f_reset),
		.rb      (rb.porta),
		.route   (route),
		.pa_out  (pa_out)
	);

endmodule

//--- tests/clock_gen.sv
module clock_gen (
	output logic cpuclk,
	output logic f_reset
);

	// Period of 40.
	initial begin
		cpuclk = 1'b0;
		forever #20 cpuclk = ~cpuclk;
	end

	initial begin
		f_reset = 1'b1;
		repeat (3) @(posedge cpuclk);
		@(negedge cpuclk);
		f_reset = 1'b0;
	end

endmodule

//--- tests/tb_trig.sv
module tb_trig;

	localparam int max_cycles = 3000;

	logic             cpuclk;
	logic             f_reset;
	logic [15:0]      cpu_adr;
	logic [7:0]       cpu_wdata;
	logic             cpu_wr;
	logic [7:0]       cpu_rdata;
	logic [14:0]      dut_adr;
	logic [7:0]       dut_data;
	logic             dut_rd;
	logic             dut_wr;
	logic             dut_cs_rom;
	logic             dut_cs_xram;
	logic             dut_phi;
	logic             dut_reset;
	logic [7:0]       pa_out;
	trig_pkg::route_t route;

	// Register model.
	logic [31:0] m_atom;
	logic [3:0]  m_ones;
	logic [3:0]  m_cmp_route [4];
	logic [28:0] m_cmp_val [4];
	logic [28:0] m_cmp_mask [4];
	logic [7:0]  m_set;
	logic [7:0]  m_clr;
	logic [3:0]  m_tset;
	logic [3:0]  m_tclr;
	logic [7:0]  m_pa;
	logic [3:0]  m_route;
	logic [28:0] m_snap;
	logic        m_prev_wr;
	int          err_count;
	int          check_count;
	int          cycles;

	clock_gen u_clock_gen (.cpuclk(cpuclk), .f_reset(f_reset));

	trig_top DUT (.*);

	function automatic logic [3:0] expected_route(input logic [28:0] snap);
		logic [3:0] r;
		r = m_ones;
		for (int i = 0; i < 4; i++)
			if ((snap & m_cmp_mask[i]) == (m_cmp_val[i] & m_cmp_mask[i]))
				r = r | m_cmp_route[i];
		return r;
	endfunction

	function automatic logic [7:0] expected_pa();
		logic [7:0] s;
		logic [7:0] c;
		s = m_set;
		c = m_clr;
		s[0] = s[0] | (|(m_tset & m_route));
		c[0] = c[0] | (|(m_tclr & m_route));
		return (m_pa | s) & ~c;
	endfunction

	function automatic logic [7:0] expected_rdata(input logic [15:0] adr);
		logic [31:0] w;
		w = {3'b000, m_snap};
		if (adr[15:2] == trig_pkg::adr_atom_base[15:2])
			return m_atom[adr[1:0]*8 +: 8];
		if (adr == trig_pkg::adr_pa_base)
			return m_pa;
		if (adr[15:2] == trig_pkg::adr_dut_base[15:2])
			return w[adr[1:0]*8 +: 8];
		return 8'hff;
	endfunction

	// Advance the model by one clock edge.
	task automatic step_model();
		logic [3:0] nroute;
		logic [7:0] npa;
		logic       first;
		first = cpu_wr && !m_prev_wr && !f_reset;
		nroute = expected_route(m_snap);
		npa = expected_pa();
		m_snap = {dut_reset, dut_phi, dut_wr, dut_rd, dut_cs_xram,
			dut_data, dut_cs_rom, dut_adr};
		m_prev_wr = f_reset ? 1'b0 : cpu_wr;
		m_route = f_reset ? 4'h0 : nroute;
		m_pa = f_reset ? 8'h00 : npa;
		if (f_reset) begin
			{m_ones, m_set, m_clr, m_tset, m_tclr} = '0;
			for (int i = 0; i < 4; i++) begin
				m_cmp_route[i] = '0;
				m_cmp_val[i] = '0;
				m_cmp_mask[i] = '0;
			end
		end
		if (first && cpu_adr[15:2] == trig_pkg::adr_atom_base[15:2])
			m_atom[cpu_adr[1:0]*8 +: 8] = cpu_wdata;
		if (first && cpu_adr == trig_pkg::adr_ones_set)
			m_ones = m_atom[3:0];
		for (int i = 0; i < 4; i++) begin
			if (first && cpu_adr == 16'hff51 && cpu_wdata[i])
				m_cmp_route[i] = m_atom[3:0];
			if (first && cpu_adr == 16'hff53 && cpu_wdata[i])
				m_cmp_val[i] = m_atom[28:0];
			if (first && cpu_adr == 16'hff53 && cpu_wdata[i+4])
				m_cmp_mask[i] = m_atom[28:0];
		end
		if (first && cpu_adr[15:2] == trig_pkg::adr_pa_base[15:2]) begin
			case (cpu_adr[1:0])
			2'd0: m_set = cpu_wdata;
			2'd1: m_clr = cpu_wdata;
			2'd2: if (cpu_wdata == 8'd1) m_tset = m_atom[3:0];
			2'd3: if (cpu_wdata == 8'd1) m_tclr = m_atom[3:0];
			endcase
		end
	endtask

	task automatic expect_now(input string what, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Outputs compared against the model every cycle.
	initial begin
		forever begin
			@(posedge cpuclk);
			step_model();
			#10;
			if (!f_reset) begin
				expect_now("route", route, m_route);
				expect_now("pa_out", pa_out, m_pa);
				expect_now("cpu_rdata", cpu_rdata, expected_rdata(cpu_adr));
			end
		end
	end

	task automatic write_reg(input logic [15:0] adr, input logic [7:0] data);
		@(negedge cpuclk);
		cpu_adr = adr;
		cpu_wdata = data;
		cpu_wr = 1'b1;
		@(negedge cpuclk);
		cpu_wr = 1'b0;
		cpu_adr = 16'h0000;
	endtask

	task automatic write_atom(input logic [31:0] v);
		for (int b = 0; b < 4; b++)
			write_reg(trig_pkg::adr_atom_base + 16'(b), v[b*8 +: 8]);
	endtask

	task automatic read_expect(input logic [15:0] adr, input logic [7:0] exp);
		@(negedge cpuclk);
		cpu_adr = adr;
		@(posedge cpuclk);
		#10;
		expect_now("read-back", cpu_rdata, exp);
	endtask

	task automatic drive_bus(input logic [28:0] w);
		{dut_reset, dut_phi, dut_wr, dut_rd, dut_cs_xram, dut_data, dut_cs_rom, dut_adr} = w;
	endtask

	task automatic wait_checked();
		@(posedge cpuclk);
		#10;
	endtask

	initial begin
		logic [31:0] wx;
		logic [28:0] w;
		logic [28:0] cv [4];
		int          k;
		{cpu_adr, cpu_wdata, cpu_wr} = '0;
		drive_bus('0);
		err_count = 0;
		check_count = 0;
		void'($urandom(32'hf821_d609));
		wait (f_reset == 1'b0);

		wait_checked();
		expect_now("pa_out after reset", pa_out, 8'h00);
		expect_now("route after reset", route, 4'h0);
		read_expect(16'h0000, 8'hff);
		read_expect(16'hff41, 8'hff);
		read_expect(16'hff44, 8'hff);

		write_atom(32'h1234_5678);
		for (int b = 0; b < 4; b++)
			read_expect(trig_pkg::adr_atom_base + 16'(b), 8'(32'h1234_5678 >> (b * 8)));
		// Held write moves on to 0xff14 without a new edge.
		@(negedge cpuclk);
		cpu_adr = 16'hff10;
		cpu_wdata = 8'h05;
		cpu_wr = 1'b1;
		@(negedge cpuclk);
		cpu_adr = trig_pkg::adr_ones_set;
		repeat (2) @(negedge cpuclk);
		cpu_wr = 1'b0;
		cpu_adr = 16'h0000;
		repeat (2) @(negedge cpuclk);
		wait_checked();
		expect_now("route after held write", route, 4'h0);
		write_reg(trig_pkg::adr_ones_set, 8'h00);
		wait_checked();
		expect_now("route from ones-set", route, 4'h5);

		write_atom(32'h0);
		write_reg(trig_pkg::adr_ones_set, 8'h00);
		write_atom(32'h1);
		write_reg(16'hff42, 8'h01);
		write_reg(trig_pkg::adr_ones_set, 8'h00);
		wait_checked();
		expect_now("route 0", route, 4'h1);
		expect_now("pa_out bit 0 early", pa_out[0], 1'b0);
		wait_checked();
		expect_now("pa_out bit 0 triggered", pa_out[0], 1'b1);
		write_reg(16'hff43, 8'h01);
		repeat (2) @(negedge cpuclk);
		wait_checked();
		expect_now("pa_out bit 0 trigger reset", pa_out[0], 1'b0);
		write_atom(32'h0);
		write_reg(16'hff42, 8'h01);
		write_reg(16'hff43, 8'h01);
		write_reg(trig_pkg::adr_ones_set, 8'h00);

		write_reg(16'hff40, 8'hf0);
		@(negedge cpuclk);
		wait_checked();
		expect_now("pa_out set mask", pa_out, 8'hf0);
		write_reg(16'hff41, 8'h30);
		@(negedge cpuclk);
		wait_checked();
		expect_now("pa_out reset wins", pa_out, 8'hc0);
		write_reg(16'hff40, 8'h00);
		write_reg(16'hff41, 8'hff);
		@(negedge cpuclk);
		wait_checked();
		expect_now("pa_out cleared", pa_out, 8'h00);
		write_reg(16'hff41, 8'h00);

		// Comparator i drives route i.
		for (int i = 0; i < 4; i++) begin
			write_atom(32'(1 << i));
			write_reg(16'hff51, 8'(1 << i));
		end
		repeat (3) begin
			for (int i = 0; i < 4; i++) begin
				cv[i] = 29'($urandom);
				write_atom({3'b000, cv[i]});
				write_reg(16'hff53, 8'(1 << i));
				write_atom($urandom & $urandom & $urandom);
				write_reg(16'hff53, 8'(8'h10 << i));
			end
			repeat (40) begin
				k = $urandom % 6;
				w = 29'($urandom);
				if (k < 4)
					w = cv[k] ^ 29'($urandom & $urandom & $urandom & $urandom);
				@(negedge cpuclk);
				drive_bus(w);
			end
		end

		for (int b = 0; b < 4; b++) begin
			w = 29'($urandom);
			@(negedge cpuclk);
			drive_bus(w);
			cpu_adr = trig_pkg::adr_dut_base + 16'(b);
			wait_checked();
			wx = {3'b000, w};
			expect_now("snapshot byte", cpu_rdata, wx[b*8 +: 8]);
		end
		repeat (4) @(negedge cpuclk);

		$display("Checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < max_cycles) begin
			@(posedge cpuclk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", max_cycles);
		$display("Checks: %0d, errors: %0d", check_count, err_count);
		$display("Test failed");
		$finish;
	end

endmodule

//--- flist.f
logic/trig_pkg.sv
logic/reg_bus_if.sv
logic/host_decode.sv
logic/bus_match.sv
logic/port_a_ctrl.sv
logic/trig_top.sv
tests/clock_gen.sv
tests/tb_trig.sv
